/* hdl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

   //////////////////////////////
   // Widths and depths
   //////////////////////////////
   localparam int XLEN       = 32;                 // Data and address word
   localparam int ROB_WIDTH  = 5;                  // ROB index, wrap bit on top
   localparam int PRF_WIDTH  = 6;                  // Physical register tag
   localparam int SQ_DEPTH   = 4;                  // Store queue entries
   localparam int SQ_PTR_W   = 2;                  // Head/tail pointer bits
   localparam int SQ_CNT_W   = 3;                  // 0 .. SQ_DEPTH
   localparam int DMEM_WORDS = 256;                // Data memory depth
   localparam int DMEM_AW    = 8;                  // Word index bits

   localparam logic [6:0] OPC_LOAD  = 7'b0000011;  // LW
   localparam logic [6:0] OPC_STORE = 7'b0100011;  // SW

   typedef logic [ROB_WIDTH:0] robid_t;            // Top bit is wrap

   //////////////////////////////
   // Instruction word layouts
   //////////////////////////////
   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } lsu_itype_t;

   typedef struct packed {
      logic [6:0]  imm_hi;                         // imm[11:5]
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  imm_lo;                         // imm[4:0]
      logic [6:0]  opcode;
   } lsu_stype_t;

   typedef union packed {
      lsu_itype_t itype;                           // Load view
      lsu_stype_t stype;                           // Store view
   } lsu_instr_u;

   //////////////////////////////
   // Port bundles
   //////////////////////////////
   typedef struct packed {
      logic                 valid;
      lsu_instr_u           instr;
      logic [XLEN-1:0]      rs1_val;
      logic [XLEN-1:0]      rs2_val;               // Store data
      logic [PRF_WIDTH-1:0] prd;
      robid_t               robid;
   } lsu_issue_t;

   typedef struct packed {
      logic               valid;
      robid_t             robid;
      logic [DMEM_AW-1:0] idx;
      logic [XLEN-1:0]    data;
   } sq_alloc_t;

   typedef struct packed {
      logic               valid;
      logic [DMEM_AW-1:0] idx;
      robid_t             robid;                   // Load's own id
   } sq_fwd_req_t;

   typedef struct packed {
      logic            hit;
      logic [XLEN-1:0] data;
   } sq_fwd_rsp_t;

   typedef struct packed {
      logic   valid;
      robid_t robid;
   } retire_t;

   typedef struct packed {
      logic   valid;
      robid_t robid;                               // Branch id, kills younger
   } flush_t;

   typedef struct packed {
      logic               valid;
      logic [DMEM_AW-1:0] idx;
      logic [XLEN-1:0]    data;
   } mem_wr_t;

   typedef struct packed {
      logic                 valid;
      logic [PRF_WIDTH-1:0] prd;
      robid_t               robid;
      logic [XLEN-1:0]      data;
   } wb_t;

   // True when a is younger than b in ROB order
   function automatic logic is_younger(robid_t a, robid_t b);
      logic same_wrap;
      same_wrap = (a[ROB_WIDTH] == b[ROB_WIDTH]);
      if (same_wrap) begin
         return a[ROB_WIDTH-1:0] > b[ROB_WIDTH-1:0];
      end
      return a[ROB_WIDTH-1:0] < b[ROB_WIDTH-1:0];   // Wrapped past b
   endfunction

endpackage

`default_nettype wire

/* hdl/data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module data_memory (
   input  wire logic                          clk,
   input  wire logic [lsu_pkg::DMEM_AW-1:0]   rd_idx,
   output logic      [lsu_pkg::XLEN-1:0]      rd_data,
   input  wire lsu_pkg::mem_wr_t              wr
);

   logic [lsu_pkg::XLEN-1:0] mem [lsu_pkg::DMEM_WORDS];   // Word array, no init

   //////////////////////////////
   // Write port, drained stores
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (wr.valid) begin
         mem[wr.idx] <= wr.data;
      end
   end

   //////////////////////////////
   // Read port, one cycle
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (wr.valid && (wr.idx == rd_idx)) begin
         rd_data <= wr.data;                    // Collision, new data wins
      end else begin
         rd_data <= mem[rd_idx];
      end
   end

endmodule

`default_nettype wire

/* hdl/lsu_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe (
   input  wire logic                        clk,
   input  wire logic                        rst,
   input  wire lsu_pkg::lsu_issue_t         issue,
   input  wire lsu_pkg::flush_t             flush,
   output lsu_pkg::sq_alloc_t               sq_alloc,
   output lsu_pkg::sq_fwd_req_t             fwd_req,
   input  wire lsu_pkg::sq_fwd_rsp_t        fwd_rsp,
   output logic [lsu_pkg::DMEM_AW-1:0]      mem_rd_idx,
   input  wire logic [lsu_pkg::XLEN-1:0]    mem_rd_data,
   output lsu_pkg::wb_t                     wb
);

   // Stage one, op after address add
   typedef struct packed {
      logic                          valid;
      logic                          store;     // Else load
      logic [lsu_pkg::DMEM_AW-1:0]   idx;
      logic [lsu_pkg::XLEN-1:0]      data;
      logic [lsu_pkg::PRF_WIDTH-1:0] prd;
      lsu_pkg::robid_t               robid;
   } s1_t;

   // Stage two, load waiting on RAM
   typedef struct packed {
      logic                          valid;
      logic [lsu_pkg::PRF_WIDTH-1:0] prd;
      lsu_pkg::robid_t               robid;
      logic                          hit;       // Queue supplied data
      logic [lsu_pkg::XLEN-1:0]      fdata;
   } s2_t;

   lsu_pkg::lsu_instr_u        instr;
   logic [6:0]                 opcode;
   logic                       is_load;
   logic                       is_store;
   logic [lsu_pkg::XLEN-1:0]   imm;
   logic [lsu_pkg::XLEN-1:0]   addr;
   logic                       kill0;
   logic                       kill1;
   logic                       kill2;
   s1_t                        s1;
   s2_t                        s2;

   //////////////////////////////
   // Decode and address add
   //////////////////////////////
   always_comb begin
      instr    = issue.instr;
      opcode   = instr.itype.opcode;                // Same bits in both views
      is_load  = (opcode == lsu_pkg::OPC_LOAD);
      is_store = (opcode == lsu_pkg::OPC_STORE);
      if (is_store) begin
         imm = {{(lsu_pkg::XLEN-12){instr.stype.imm_hi[6]}},
                instr.stype.imm_hi, instr.stype.imm_lo};   // Split immediate
      end else begin
         imm = {{(lsu_pkg::XLEN-12){instr.itype.imm[11]}}, instr.itype.imm};
      end
      addr = issue.rs1_val + imm;                   // Byte address
   end

   // Flush kills per stage, same cycle
   assign kill0 = flush.valid && lsu_pkg::is_younger(issue.robid, flush.robid);
   assign kill1 = flush.valid && lsu_pkg::is_younger(s1.robid, flush.robid);
   assign kill2 = flush.valid && lsu_pkg::is_younger(s2.robid, flush.robid);

   //////////////////////////////
   // Pipeline registers
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         s1.valid <= 1'b0;
         s2.valid <= 1'b0;
      end else begin
         s1.valid <= issue.valid && (is_load || is_store) && !kill0;
         s2.valid <= s1.valid && !s1.store && !kill1;   // Loads only
      end
      s1.store <= is_store;
      s1.idx   <= addr[lsu_pkg::DMEM_AW+1:2];       // Word index, low bits dropped
      s1.data  <= issue.rs2_val;
      s1.prd   <= issue.prd;
      s1.robid <= issue.robid;
      s2.prd   <= s1.prd;
      s2.robid <= s1.robid;
      s2.hit   <= fwd_rsp.hit;
      s2.fdata <= fwd_rsp.data;
   end

   //////////////////////////////
   // Stage one outputs
   //////////////////////////////
   always_comb begin
      sq_alloc.valid = s1.valid && s1.store && !kill1;
      sq_alloc.robid = s1.robid;
      sq_alloc.idx   = s1.idx;
      sq_alloc.data  = s1.data;
      fwd_req.valid  = s1.valid && !s1.store && !kill1;
      fwd_req.idx    = s1.idx;
      fwd_req.robid  = s1.robid;
      mem_rd_idx     = s1.idx;                      // RAM data back next cycle
   end

   // Load writeback, forward beats memory
   always_comb begin
      wb.valid = s2.valid && !kill2;
      wb.prd   = s2.prd;
      wb.robid = s2.robid;
      wb.data  = s2.hit ? s2.fdata : mem_rd_data;
   end

endmodule

`default_nettype wire

/* hdl/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue (
   input  wire logic                        clk,
   input  wire logic                        rst,
   input  wire lsu_pkg::sq_alloc_t          alloc,
   input  wire lsu_pkg::sq_fwd_req_t        fwd_req,
   output lsu_pkg::sq_fwd_rsp_t             fwd_rsp,
   input  wire lsu_pkg::retire_t            retire0,
   input  wire lsu_pkg::retire_t            retire1,
   input  wire lsu_pkg::flush_t             flush,
   output lsu_pkg::mem_wr_t                 mem_wr,
   output logic [lsu_pkg::SQ_CNT_W-1:0]     sq_credit
);

   typedef struct packed {
      logic                        valid;
      logic                        commit;      // Retired, may drain
      lsu_pkg::robid_t             robid;
      logic [lsu_pkg::DMEM_AW-1:0] idx;
      logic [lsu_pkg::XLEN-1:0]    data;
   } sq_entry_t;

   sq_entry_t                        q [lsu_pkg::SQ_DEPTH];
   logic [lsu_pkg::SQ_PTR_W-1:0]     head;        // Oldest entry
   logic [lsu_pkg::SQ_PTR_W-1:0]     tail;        // Next free slot
   logic [lsu_pkg::SQ_PTR_W-1:0]     alloc_ptr;   // Tail after flush rewind
   logic [lsu_pkg::SQ_DEPTH-1:0]     kill;
   logic [lsu_pkg::SQ_DEPTH-1:0]     ret_hit;
   logic [lsu_pkg::SQ_CNT_W-1:0]     kill_cnt;
   logic                             alloc_ret;   // Retire meets its own alloc
   logic                             drain;

   //////////////////////////////
   // Flush and retire matching
   //////////////////////////////
   always_comb begin
      kill_cnt = '0;
      for (int i = 0; i < lsu_pkg::SQ_DEPTH; i++) begin
         kill[i] = flush.valid && q[i].valid && !q[i].commit &&
                   lsu_pkg::is_younger(q[i].robid, flush.robid);
         kill_cnt = kill_cnt + {{(lsu_pkg::SQ_CNT_W-1){1'b0}}, kill[i]};
         ret_hit[i] = q[i].valid &&
                      ((retire0.valid && (retire0.robid == q[i].robid)) ||
                       (retire1.valid && (retire1.robid == q[i].robid)));
      end
   end

   assign alloc_ret = (retire0.valid && (retire0.robid == alloc.robid)) ||
                      (retire1.valid && (retire1.robid == alloc.robid));

   // Killed entries form the tail end, so just rewind
   assign alloc_ptr = tail - kill_cnt[lsu_pkg::SQ_PTR_W-1:0];

   //////////////////////////////
   // Drain to memory
   //////////////////////////////
   assign drain = q[head].valid && q[head].commit;  // Head only, in order

   always_comb begin
      mem_wr.valid = drain;
      mem_wr.idx   = q[head].idx;
      mem_wr.data  = q[head].data;
   end

   // Freed this cycle, drain plus flush
   assign sq_credit = {{(lsu_pkg::SQ_CNT_W-1){1'b0}}, drain} + kill_cnt;

   //////////////////////////////
   // Entry state update
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         head <= '0;
         tail <= '0;
         for (int i = 0; i < lsu_pkg::SQ_DEPTH; i++) begin
            q[i].valid  <= 1'b0;
            q[i].commit <= 1'b0;
         end
      end else begin
         for (int i = 0; i < lsu_pkg::SQ_DEPTH; i++) begin
            if (ret_hit[i]) begin
               q[i].commit <= 1'b1;                 // Seen next cycle
            end
            if (kill[i]) begin
               q[i].valid <= 1'b0;
            end
         end
         if (drain) begin
            q[head].valid  <= 1'b0;
            q[head].commit <= 1'b0;
         end
         if (alloc.valid) begin
            q[alloc_ptr].valid  <= 1'b1;            // Overrides drain on same slot
            q[alloc_ptr].commit <= alloc_ret;
         end
         head <= head + {{(lsu_pkg::SQ_PTR_W-1){1'b0}}, drain};
         tail <= alloc_ptr + {{(lsu_pkg::SQ_PTR_W-1){1'b0}}, alloc.valid};
      end
      if (alloc.valid) begin
         q[alloc_ptr].robid <= alloc.robid;         // Payload, no reset
         q[alloc_ptr].idx   <= alloc.idx;
         q[alloc_ptr].data  <= alloc.data;
      end
   end

   //////////////////////////////
   // Store to load forwarding
   //////////////////////////////
   // Walk oldest to youngest, last match is the youngest older store
   always_comb begin
      logic [lsu_pkg::SQ_PTR_W-1:0] p;
      fwd_rsp = '0;
      p       = head;
      for (int k = 0; k < lsu_pkg::SQ_DEPTH; k++) begin
         p = head + k[lsu_pkg::SQ_PTR_W-1:0];
         if (q[p].valid && (q[p].idx == fwd_req.idx) &&
             lsu_pkg::is_younger(fwd_req.robid, q[p].robid)) begin
            fwd_rsp.hit  = fwd_req.valid;
            fwd_rsp.data = q[p].data;
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
   input  wire logic                        clk,
   input  wire logic                        rst,
   input  wire lsu_pkg::lsu_issue_t         issue,
   input  wire lsu_pkg::retire_t            retire0,
   input  wire lsu_pkg::retire_t            retire1,
   input  wire lsu_pkg::flush_t             flush,
   output lsu_pkg::wb_t                     wb,
   output logic [lsu_pkg::SQ_CNT_W-1:0]     sq_credit
);

   lsu_pkg::sq_alloc_t              sq_alloc;      // Pipe to queue
   lsu_pkg::sq_fwd_req_t            fwd_req;
   lsu_pkg::sq_fwd_rsp_t            fwd_rsp;       // Queue back to pipe
   lsu_pkg::mem_wr_t                mem_wr;        // Drained store
   logic [lsu_pkg::DMEM_AW-1:0]     mem_rd_idx;
   logic [lsu_pkg::XLEN-1:0]        mem_rd_data;

   //////////////////////////////
   // Address gen and writeback
   //////////////////////////////
   lsu_pipe lsu_pipe_inst (
      .clk         (clk),
      .rst         (rst),
      .issue       (issue),
      .flush       (flush),
      .sq_alloc    (sq_alloc),
      .fwd_req     (fwd_req),
      .fwd_rsp     (fwd_rsp),
      .mem_rd_idx  (mem_rd_idx),
      .mem_rd_data (mem_rd_data),
      .wb          (wb)
   );

   store_queue store_queue_inst (
      .clk       (clk),
      .rst       (rst),
      .alloc     (sq_alloc),
      .fwd_req   (fwd_req),
      .fwd_rsp   (fwd_rsp),
      .retire0   (retire0),
      .retire1   (retire1),
      .flush     (flush),
      .mem_wr    (mem_wr),
      .sq_credit (sq_credit)                       // Credits back to issuer
   );

   data_memory data_memory_inst (
      .clk     (clk),
      .rd_idx  (mem_rd_idx),
      .rd_data (mem_rd_data),
      .wr      (mem_wr)
   );

endmodule

`default_nettype wire

/* sim/lsu_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_assertions (
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire logic                          alloc_valid,
   input  wire logic                          tail_busy,    // Next free slot still valid
   input  wire lsu_pkg::retire_t              retire0,
   input  wire lsu_pkg::retire_t              retire1,
   input  wire logic                          drain,
   input  wire lsu_pkg::robid_t               head_robid,   // Id of the oldest entry
   input  wire logic [lsu_pkg::SQ_CNT_W-1:0]  sq_credit
);

   int fail_count = 0;                                      // Fired assertion tally
   logic [2**(lsu_pkg::ROB_WIDTH+1)-1:0] retired;           // One bit per ROB id

   // Set by a retire port and cleared by the drain of that id
   always_ff @(posedge clk) begin
      if (rst) begin
         retired <= '0;
      end else begin
         if (retire0.valid) begin
            retired[retire0.robid] <= 1'b1;
         end
         if (retire1.valid) begin
            retired[retire1.robid] <= 1'b1;
         end
         if (drain) begin
            retired[head_robid] <= 1'b0;                    // Store left for memory
         end
      end
   end

   // Credit protocol keeps the queue from overflowing
   no_overflow: assert property (@(posedge clk) disable iff (rst)
      alloc_valid |-> !tail_busy)
      else begin
         fail_count++;
         $error("Store allocated into a full queue");
      end

   // Drained head must have been retired earlier
   drain_committed: assert property (@(posedge clk) disable iff (rst)
      drain |-> retired[head_robid])
      else begin
         fail_count++;
         $error("Drain of a head that was never retired");
      end

   credit_range: assert property (@(posedge clk) disable iff (rst)
      sq_credit <= lsu_pkg::SQ_DEPTH)
      else begin
         fail_count++;
         $error("Credit return above queue depth");
      end

endmodule

bind store_queue lsu_assertions lsu_assertions_inst (
   .clk         (clk),
   .rst         (rst),
   .alloc_valid (alloc.valid),
   .tail_busy   (q[tail].valid),
   .retire0     (retire0),
   .retire1     (retire1),
   .drain       (mem_wr.valid),
   .head_robid  (q[head].robid),
   .sq_credit   (sq_credit)
);

`default_nettype wire

/* sim/tb_lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;

   localparam int MAX_STEPS = 64;

   typedef enum logic [2:0] {K_IDLE, K_LOAD, K_STORE, K_RET0, K_RET1, K_FLUSH} kind_t;

   typedef struct packed {
      logic [2:0]           test;
      kind_t                kind;
      lsu_pkg::robid_t      robid;
      logic [31:0]          rs1;
      logic [11:0]          imm;
      logic [31:0]          data;                // Store data
      logic [5:0]           prd;
      logic [31:0]          exp;                 // Load data, or sq_credit if chk
      logic                 chk;                 // Credit check, or store must stall
   } step_t;

   typedef struct packed {
      logic [31:0]          due;                 // Cycle the writeback is owed
      logic [2:0]           test;
      logic [5:0]           prd;
      lsu_pkg::robid_t      robid;
      logic [31:0]          data;
   } wb_exp_t;

   logic                            clk;
   logic                            rst;
   lsu_pkg::lsu_issue_t             issue;
   lsu_pkg::retire_t                retire0;
   lsu_pkg::retire_t                retire1;
   lsu_pkg::flush_t                 flush;
   lsu_pkg::wb_t                    wb;
   logic [lsu_pkg::SQ_CNT_W-1:0]    sq_credit;

   step_t   steps [MAX_STEPS];
   step_t   idle_s;
   string   names [6];
   wb_exp_t wb_q [$];                            // Loads still owed
   int      n_steps;
   int      credits;                             // Issuer side store credits
   int      cycle;
   int      checks;
   int      errors;
   int      test_errs;

   lsu_top lsu_top_inst (
      .clk       (clk),
      .rst       (rst),
      .issue     (issue),
      .retire0   (retire0),
      .retire1   (retire1),
      .flush     (flush),
      .wb        (wb),
      .sq_credit (sq_credit)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Watchdog, bound set by table length
   initial begin
      int limit;
      #1;
      limit = n_steps * 4 + 100;
      repeat (limit) @(posedge clk);
      $display("Timeout after %0d cycles, the run did not finish", limit);
      $display("Test failed");
      $finish;
   end

   // RV32 LW/SW encodings, rs1 = x1
   function automatic lsu_pkg::lsu_instr_u encode_instr(kind_t kind, logic [11:0] imm);
      lsu_pkg::lsu_instr_u w;
      if (kind == K_STORE) begin
         w = {imm[11:5], 5'd3, 5'd1, 3'b010, imm[4:0], lsu_pkg::OPC_STORE};
      end else begin
         w = {imm, 5'd1, 3'b010, 5'd2, lsu_pkg::OPC_LOAD};
      end
      return w;
   endfunction

   task automatic add_step(input int test, input kind_t kind, input int robid,
                           input logic [31:0] rs1, input logic [11:0] imm,
                           input logic [31:0] data, input int prd,
                           input logic [31:0] exp, input logic chk);
      step_t s;
      s.test  = 3'(test);
      s.kind  = kind;
      s.robid = lsu_pkg::robid_t'(robid);
      s.rs1   = rs1;
      s.imm   = imm;
      s.data  = data;
      s.prd   = 6'(prd);
      s.exp   = exp;
      s.chk   = chk;
      steps[n_steps] = s;
      n_steps++;
   endtask

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         test_errs++;
         $display("FAILED %s: expected %h, actual %h", what, exp, act);
      end
   endtask

   task automatic report_error(input string msg);
      errors++;
      test_errs++;
      $display("%s", msg);
   endtask

   //////////////////////////////
   // One clock of stimulus and monitor
   //////////////////////////////
   task automatic run_cycle(input step_t s);
      wb_exp_t e;
      @(posedge clk);
      cycle++;
      #1;
      issue         = '0;
      issue.valid   = (s.kind == K_LOAD) || (s.kind == K_STORE);
      issue.instr   = encode_instr(s.kind, s.imm);
      issue.rs1_val = s.rs1;
      issue.rs2_val = s.data;
      issue.prd     = s.prd;
      issue.robid   = s.robid;
      retire0.valid = (s.kind == K_RET0);
      retire0.robid = s.robid;
      retire1.valid = (s.kind == K_RET1);
      retire1.robid = s.robid;
      flush.valid   = (s.kind == K_FLUSH);
      flush.robid   = s.robid;
      if (s.kind == K_STORE) credits--;          // One credit per store
      if (s.kind == K_LOAD) begin
         e.due   = cycle + 2;                    // Fixed two cycle load latency
         e.test  = s.test;
         e.prd   = s.prd;
         e.robid = s.robid;
         e.data  = s.exp;
         wb_q.push_back(e);
      end
      #3;                                        // Mid cycle, outputs settled
      credits += sq_credit;
      if (s.chk && (s.kind != K_STORE)) check_value({names[s.test], " sq_credit"}, s.exp, sq_credit);
      if (wb.valid) begin
         if (wb_q.size() == 0) begin
            report_error($sformatf("Writeback at cycle %0d with no load outstanding", cycle));
         end else begin
            e = wb_q.pop_front();
            check_value({names[e.test], " wb cycle"}, e.due, cycle);
            check_value({names[e.test], " wb prd"}, e.prd, wb.prd);
            check_value({names[e.test], " wb robid"}, e.robid, wb.robid);
            check_value({names[e.test], " wb data"}, e.data, wb.data);
         end
      end else if ((wb_q.size() > 0) && (wb_q[0].due <= cycle)) begin
         report_error($sformatf("Load writeback never arrived in %s", names[wb_q[0].test]));
         void'(wb_q.pop_front());
      end
   endtask

   // Settle loads and drains, then report the test
   task automatic finish_test(input int test);
      int waited;
      waited = 0;
      while (((wb_q.size() > 0) || (credits != lsu_pkg::SQ_DEPTH)) && (waited < 12)) begin
         run_cycle(idle_s);
         waited++;
      end
      check_value({names[test], " credits"}, lsu_pkg::SQ_DEPTH, credits);
      if (test_errs == 0) $display("ok   %s", names[test]);
      else $display("bad  %s, %0d errors", names[test], test_errs);
      test_errs = 0;
   endtask

   task automatic build_table();
      add_step(0, K_IDLE,   0, 32'h000, 12'h000, 32'h0,         0,  32'h0,         1);
      add_step(0, K_IDLE,   0, 32'h000, 12'h000, 32'h0,         0,  32'h0,         1);
      add_step(1, K_STORE,  1, 32'h100, 12'h010, 32'ha5a5_0001, 0,  32'h0,         0);
      add_step(1, K_RET0,   1, 32'h000, 12'h000, 32'h0,         0,  32'h0,         0);
      add_step(1, K_IDLE,   0, 32'h000, 12'h000, 32'h0,         0,  32'h1,         1);
      add_step(1, K_LOAD,   2, 32'h100, 12'h010, 32'h0,         5,  32'ha5a5_0001, 0);
      add_step(2, K_STORE,  3, 32'h140, 12'h000, 32'h1111_1111, 0,  32'h0,         0);
      add_step(2, K_STORE,  4, 32'h100, 12'h040, 32'h2222_2222, 0,  32'h0,         0);
      add_step(2, K_LOAD,   5, 32'h140, 12'h000, 32'h0,         7,  32'h2222_2222, 0);
      add_step(2, K_RET0,   3, 32'h000, 12'h000, 32'h0,         0,  32'h0,         0);
      add_step(2, K_RET1,   4, 32'h000, 12'h000, 32'h0,         0,  32'h0,         0);
      add_step(3, K_STORE,  6, 32'h300, 12'hffc, 32'h3333_0003, 0,  32'h0,         0);
      add_step(3, K_RET0,   6, 32'h000, 12'h000, 32'h0,         0,  32'h0,         0);
      add_step(3, K_LOAD,   7, 32'h2f0, 12'h00c, 32'h0,         9,  32'h3333_0003, 0);
      add_step(3, K_LOAD,   8, 32'h400, 12'hefc, 32'h0,         10, 32'h3333_0003, 0);
      add_step(4, K_STORE,  9, 32'h180, 12'h000, 32'h4444_0004, 0,  32'h0,         0);
      add_step(4, K_RET0,   9, 32'h000, 12'h000, 32'h0,         0,  32'h0,         0);
      add_step(4, K_STORE, 10, 32'h180, 12'h000, 32'h5555_0005, 0,  32'h0,         0);
      add_step(4, K_IDLE,   0, 32'h000, 12'h000, 32'h0,         0,  32'h0,         0);
      add_step(4, K_FLUSH,  9, 32'h000, 12'h000, 32'h0,         0,  32'h1,         1);
      add_step(4, K_LOAD,  11, 32'h180, 12'h000, 32'h0,         11, 32'h4444_0004, 0);
      for (int k = 0; k < 4; k++) begin          // Fill every queue entry
         add_step(5, K_STORE, 12 + k, 32'h1c0, 12'(4 * k), 32'h6000_0000 + k, 0, 32'h0, 0);
      end
      add_step(5, K_RET0,  12, 32'h000, 12'h000, 32'h0,         0,  32'h0,         0);
      add_step(5, K_STORE, 16, 32'h1c0, 12'h010, 32'h6000_0004, 0,  32'h0,         1);
      add_step(5, K_RET1,  13, 32'h000, 12'h000, 32'h0,         0,  32'h0,         0);
      add_step(5, K_RET0,  14, 32'h000, 12'h000, 32'h0,         0,  32'h0,         0);
      add_step(5, K_RET1,  15, 32'h000, 12'h000, 32'h0,         0,  32'h0,         0);
      add_step(5, K_RET0,  16, 32'h000, 12'h000, 32'h0,         0,  32'h0,         0);
      for (int k = 0; k < 5; k++) begin          // Read all five back
         add_step(5, K_LOAD, 17 + k, 32'h1c0, 12'(4 * k), 32'h0, 12 + k, 32'h6000_0000 + k, 0);
      end
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////
   initial begin
      int cur;
      int hold;
      rst       = 1'b1;
      issue     = '0;
      retire0   = '0;
      retire1   = '0;
      flush     = '0;
      idle_s    = '0;
      credits   = lsu_pkg::SQ_DEPTH;             // Issuer starts with a full queue
      cycle     = 0;
      checks    = 0;
      errors    = 0;
      test_errs = 0;
      n_steps   = 0;
      names[0]  = "reset";
      names[1]  = "store_drain_load";
      names[2]  = "forwarding";
      names[3]  = "address_forms";
      names[4]  = "flush";
      names[5]  = "credit_backpressure";
      build_table();
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      cur = 0;
      for (int i = 0; i < n_steps; i++) begin
         if (steps[i].test != cur) begin
            finish_test(cur);
            cur = steps[i].test;
         end
         if (steps[i].kind == K_STORE) begin
            hold = 0;
            while (credits == 0) begin           // Out of credits, hold the store
               run_cycle(idle_s);
               hold++;
            end
            if (steps[i].chk) check_value({names[cur], " store held"}, 1, hold > 0);
         end
         run_cycle(steps[i]);
      end
      finish_test(cur);
      if (lsu_top_inst.store_queue_inst.lsu_assertions_inst.fail_count != 0) begin
         report_error("A store queue assertion fired during the run");
      end
      $display("%0d tests, %0d checks, %0d errors", cur + 1, checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
hdl/lsu_pkg.sv
hdl/data_memory.sv
hdl/lsu_pipe.sv
hdl/store_queue.sv
hdl/lsu_top.sv
sim/lsu_assertions.sv
sim/tb_lsu_top.sv

/* Bender.yml */
package:
  name: lsu_mem

sources:
  - hdl/lsu_pkg.sv
  - hdl/data_memory.sv
  - hdl/lsu_pipe.sv
  - hdl/store_queue.sv
  - hdl/lsu_top.sv
  - target: simulation
    files:
      - sim/lsu_assertions.sv
      - sim/tb_lsu_top.sv
